//--- src/dfdPkg.sv
// Single trace instance; 64-bit entries, 256-entry buffer, 12-bit APB address space
package dfdPkg;

  // ****************************************
  // Widths
  // ****************************************
  localparam int TraceEntryWidth = 64;
  localparam int TimeStampWidth  = 16;
  localparam int RetireCntWidth  = 12;
  localparam int ApbAddrWidth    = 12;
  localparam int ApbDataWidth    = 32;
  localparam int BufDepth        = 256;
  localparam int BufIdxWidth     = 8;

  typedef logic [TraceEntryWidth-1:0] traceEntry_t;
  typedef logic [TimeStampWidth-1:0]  timeStamp_t;
  typedef logic [RetireCntWidth-1:0]  retireCnt_t;
  typedef logic [ApbAddrWidth-1:0]    apbAddr_t;
  typedef logic [ApbDataWidth-1:0]    apbData_t;
  // One extra bit so a full count of BufDepth fits
  typedef logic [BufIdxWidth:0]       bufPtr_t;

  typedef enum logic [2:0] {
    itNone      = 3'd0,
    itBranch    = 3'd1,
    itJump      = 3'd2,
    itException = 3'd3,
    itReturn    = 3'd4
  } instType_e;

  // ****************************************
  // Register map
  // ****************************************
  localparam apbAddr_t RegCtrl    = 12'h000;
  localparam apbAddr_t RegStatus  = 12'h004;
  localparam apbAddr_t RegDbgMask = 12'h008;
  localparam apbAddr_t RegDropCnt = 12'h00C;
  localparam apbAddr_t RegTime    = 12'h010;
  localparam apbAddr_t RegRdIdx   = 12'h014;
  localparam apbAddr_t RegRdLo    = 12'h018;
  localparam apbAddr_t RegRdHi    = 12'h01C;
  localparam apbAddr_t RegClear   = 12'h020;

endpackage

//--- src/instTracePacker.sv
// Core must hold typed retirements while o_backpressure is high; count saturates at 4095
`timescale 1ns/1ps

module instTracePacker (
  input  logic                i_clk,
  input  logic                i_rstN,
  input  logic                i_active,
  input  logic                i_instEn,
  input  dfdPkg::timeStamp_t  i_timeStamp,
  input  logic [1:0]          i_iRetire,
  input  dfdPkg::instType_e   i_iType,
  input  logic [31:0]         i_iAddr,
  input  logic                i_grant,
  output logic                o_pktValid,
  output dfdPkg::traceEntry_t o_pkt,
  output logic                o_backpressure
);
  import dfdPkg::*;

  logic                    activeQ;
  logic                    startEdge;
  logic                    counting;
  logic                    capture;
  logic                    slotFree;
  logic                    load;
  retireCnt_t              accCnt;
  retireCnt_t              accBase;
  logic [RetireCntWidth:0] sum;
  retireCnt_t              newCnt;

  // First active cycle starts from an empty accumulator
  assign startEdge = i_active & ~activeQ;
  assign counting  = i_active & i_instEn;
  assign accBase   = startEdge ? '0 : accCnt;

  assign sum    = {1'b0, accBase} + {{(RetireCntWidth-1){1'b0}}, i_iRetire};
  assign newCnt = sum[RetireCntWidth] ? '1 : sum[RetireCntWidth-1:0];

  assign capture  = counting & (i_iType != itNone);
  assign slotFree = ~o_pktValid | i_grant;
  assign load     = capture & slotFree;

  // ****************************************
  // Retire accumulator
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      activeQ <= 1'b0;
      accCnt  <= '0;
    end else begin
      activeQ <= i_active;
      if (load) begin
        accCnt <= '0;
      end else if (counting) begin
        accCnt <= newCnt;
      end else if (startEdge) begin
        accCnt <= '0;
      end
    end
  end

  // ****************************************
  // Packet slot
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_pktValid <= 1'b0;
    end else if (load) begin
      o_pktValid <= 1'b1;
    end else if (i_grant) begin
      o_pktValid <= 1'b0;
    end
  end

  // Source bit 0 marks an instruction entry
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_pkt <= {1'b0, i_iType, newCnt, i_timeStamp, i_iAddr};
    end
  end

  // Stall the core while the entry waits for the funnel
  assign o_backpressure = o_pktValid;

endmodule

//--- src/dbgSignalTracer.sv
// Changes are seen only between consecutive cycles; a change with the slot busy is dropped
`timescale 1ns/1ps

module dbgSignalTracer (
  input  logic                i_clk,
  input  logic                i_rstN,
  input  logic                i_active,
  input  logic                i_dbgEn,
  input  logic [31:0]         i_dbgMask,
  input  dfdPkg::timeStamp_t  i_timeStamp,
  input  logic [31:0]         i_debugBus,
  input  logic                i_grant,
  output logic                o_pktValid,
  output dfdPkg::traceEntry_t o_pkt,
  output logic [31:0]         o_dropCnt
);
  import dfdPkg::*;

  logic [31:0] masked;
  logic [31:0] maskedQ;
  logic        change;
  logic        slotFree;
  logic        load;

  assign masked   = i_debugBus & i_dbgMask;
  assign change   = i_active & i_dbgEn & (masked != maskedQ);
  assign slotFree = ~o_pktValid | i_grant;
  assign load     = change & slotFree;

  // Previous cycle's masked value
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      maskedQ <= '0;
    end else begin
      maskedQ <= masked;
    end
  end

  // ****************************************
  // Slot and drop counter
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_pktValid <= 1'b0;
      o_dropCnt  <= '0;
    end else begin
      if (load) begin
        o_pktValid <= 1'b1;
      end else if (i_grant) begin
        o_pktValid <= 1'b0;
      end
      if (change && !slotFree) begin
        o_dropCnt <= o_dropCnt + 32'd1;
      end
    end
  end

  // Debug entries leave type and count fields at zero
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_pkt <= {1'b1, 15'b0, i_timeStamp, masked};
    end
  end

endmodule

//--- src/traceFunnel.sv
// Buffer stops at 256 entries until cleared; no wrap-around, read data one cycle late
`timescale 1ns/1ps

module traceFunnel (
  input  logic                     i_clk,
  input  logic                     i_rstN,
  input  logic                     i_instValid,
  input  dfdPkg::traceEntry_t      i_instPkt,
  input  logic                     i_dbgValid,
  input  dfdPkg::traceEntry_t      i_dbgPkt,
  output logic                     o_instGrant,
  output logic                     o_dbgGrant,
  input  logic                     i_bufClear,
  input  logic [7:0]               i_rdIdx,
  output dfdPkg::traceEntry_t      o_rdEntry,
  output dfdPkg::bufPtr_t          o_wrPtr,
  output logic                     o_bufFull
);
  import dfdPkg::*;

  traceEntry_t traceMem [BufDepth];
  traceEntry_t wrEntry;
  logic        canWrite;
  logic        anyGrant;
  // High when the debug path took the last grant
  logic        lastDbg;

  // Pointer bit above the index means full
  assign o_bufFull = o_wrPtr[BufIdxWidth];

  // Hold off during a clear so no packet lands in a buffer being emptied
  assign canWrite = ~o_bufFull & ~i_bufClear;

  // ****************************************
  // Round-robin arbiter
  // ****************************************
  assign o_instGrant = canWrite & i_instValid & (~i_dbgValid | lastDbg);
  assign o_dbgGrant  = canWrite & i_dbgValid & (~i_instValid | ~lastDbg);
  assign anyGrant    = o_instGrant | o_dbgGrant;

  assign wrEntry = o_dbgGrant ? i_dbgPkt : i_instPkt;

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      lastDbg <= 1'b0;
    end else if (anyGrant) begin
      lastDbg <= o_dbgGrant;
    end
  end

  // ****************************************
  // Write pointer
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_wrPtr <= '0;
    end else if (i_bufClear) begin
      o_wrPtr <= '0;
    end else if (anyGrant) begin
      o_wrPtr <= o_wrPtr + 1'b1;
    end
  end

  // ****************************************
  // Trace RAM
  // ****************************************
  always_ff @(posedge i_clk) begin
    if (anyGrant) begin
      traceMem[o_wrPtr[BufIdxWidth-1:0]] <= wrEntry;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rdEntry <= traceMem[i_rdIdx];
  end

endmodule

//--- src/traceRegs.sv
// APB without wait states or strobes; unmapped offsets give pSlvErr, RegClear reads as 0
`timescale 1ns/1ps

module traceRegs (
  input  logic                i_clk,
  input  logic                i_rstN,
  input  dfdPkg::apbAddr_t    i_pAddr,
  input  logic                i_pSel,
  input  logic                i_pEnable,
  input  logic                i_pWrite,
  input  dfdPkg::apbData_t    i_pWData,
  output dfdPkg::apbData_t    o_pRData,
  output logic                o_pReady,
  output logic                o_pSlvErr,
  input  logic                i_traceStart,
  input  logic                i_traceStop,
  input  dfdPkg::bufPtr_t     i_wrPtr,
  input  logic                i_bufFull,
  input  dfdPkg::traceEntry_t i_rdEntry,
  input  logic [31:0]         i_dropCnt,
  output logic                o_active,
  output logic                o_instEn,
  output logic                o_dbgEn,
  output logic [31:0]         o_dbgMask,
  output dfdPkg::timeStamp_t  o_timeStamp,
  output logic [7:0]          o_rdIdx,
  output logic                o_bufClear
);
  import dfdPkg::*;

  logic     access;
  logic     wrEn;
  logic     regHit;
  apbData_t rdData;

  assign access = i_pSel & i_pEnable;
  assign wrEn   = access & i_pWrite;

  // ****************************************
  // Read decode
  // ****************************************
  always_comb begin
    regHit = 1'b1;
    rdData = '0;
    case (i_pAddr)
      RegCtrl:    rdData = {30'b0, o_dbgEn, o_instEn};
      RegStatus:  rdData = {15'b0, o_active, 6'b0, i_bufFull, i_wrPtr};
      RegDbgMask: rdData = o_dbgMask;
      RegDropCnt: rdData = i_dropCnt;
      RegTime:    rdData = {16'b0, o_timeStamp};
      RegRdIdx:   rdData = {24'b0, o_rdIdx};
      RegRdLo:    rdData = i_rdEntry[31:0];
      RegRdHi:    rdData = i_rdEntry[63:32];
      RegClear:   rdData = '0;
      default:    regHit = 1'b0;
    endcase
  end

  assign o_pRData  = rdData;
  assign o_pReady  = 1'b1;
  assign o_pSlvErr = access & ~regHit;

  // Lasts one cycle because the access phase does
  assign o_bufClear = wrEn & (i_pAddr == RegClear) & i_pWData[0];

  // ****************************************
  // Writable registers
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_instEn  <= 1'b0;
      o_dbgEn   <= 1'b0;
      o_dbgMask <= '0;
      o_rdIdx   <= '0;
    end else if (wrEn) begin
      case (i_pAddr)
        RegCtrl: begin
          o_instEn <= i_pWData[0];
          o_dbgEn  <= i_pWData[1];
        end
        RegDbgMask: o_dbgMask <= i_pWData;
        RegRdIdx:   o_rdIdx   <= i_pWData[7:0];
        default: ;
      endcase
    end
  end

  // Stop has priority over start
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_active <= 1'b0;
    end else if (i_traceStop) begin
      o_active <= 1'b0;
    end else if (i_traceStart) begin
      o_active <= 1'b1;
    end
  end

  // Free-running and wraps silently
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_timeStamp <= '0;
    end else begin
      o_timeStamp <= o_timeStamp + 1'b1;
    end
  end

endmodule

//--- src/dfdTraceTop.sv
// One trace instance; start and stop pulses come from outside, buffer read only over APB
`timescale 1ns/1ps

module dfdTraceTop (
  input  logic              i_clk,
  input  logic              i_rstN,
  input  logic              i_traceStart,
  input  logic              i_traceStop,
  input  logic [1:0]        i_iRetire,
  input  dfdPkg::instType_e i_iType,
  input  logic [31:0]       i_iAddr,
  input  logic [31:0]       i_debugBus,
  output logic              o_active,
  output logic              o_backpressure,
  input  dfdPkg::apbAddr_t  i_pAddr,
  input  logic              i_pSel,
  input  logic              i_pEnable,
  input  logic              i_pWrite,
  input  dfdPkg::apbData_t  i_pWData,
  output dfdPkg::apbData_t  o_pRData,
  output logic              o_pReady,
  output logic              o_pSlvErr
);
  import dfdPkg::*;

  logic        instEn;
  logic        dbgEn;
  logic [31:0] dbgMask;
  timeStamp_t  timeStamp;
  logic [7:0]  rdIdx;
  logic        bufClear;
  bufPtr_t     wrPtr;
  logic        bufFull;
  traceEntry_t rdEntry;
  logic [31:0] dropCnt;

  // Packer to funnel
  logic        instValid;
  traceEntry_t instPkt;
  logic        instGrant;
  logic        dbgValid;
  traceEntry_t dbgPkt;
  logic        dbgGrant;

  traceRegs uRegs (
    .i_clk        (i_clk),
    .i_rstN       (i_rstN),
    .i_pAddr      (i_pAddr),
    .i_pSel       (i_pSel),
    .i_pEnable    (i_pEnable),
    .i_pWrite     (i_pWrite),
    .i_pWData     (i_pWData),
    .o_pRData     (o_pRData),
    .o_pReady     (o_pReady),
    .o_pSlvErr    (o_pSlvErr),
    .i_traceStart (i_traceStart),
    .i_traceStop  (i_traceStop),
    .i_wrPtr      (wrPtr),
    .i_bufFull    (bufFull),
    .i_rdEntry    (rdEntry),
    .i_dropCnt    (dropCnt),
    .o_active     (o_active),
    .o_instEn     (instEn),
    .o_dbgEn      (dbgEn),
    .o_dbgMask    (dbgMask),
    .o_timeStamp  (timeStamp),
    .o_rdIdx      (rdIdx),
    .o_bufClear   (bufClear)
  );

  instTracePacker uInstPacker (
    .i_clk          (i_clk),
    .i_rstN         (i_rstN),
    .i_active       (o_active),
    .i_instEn       (instEn),
    .i_timeStamp    (timeStamp),
    .i_iRetire      (i_iRetire),
    .i_iType        (i_iType),
    .i_iAddr        (i_iAddr),
    .i_grant        (instGrant),
    .o_pktValid     (instValid),
    .o_pkt          (instPkt),
    .o_backpressure (o_backpressure)
  );

  dbgSignalTracer uDbgTracer (
    .i_clk       (i_clk),
    .i_rstN      (i_rstN),
    .i_active    (o_active),
    .i_dbgEn     (dbgEn),
    .i_dbgMask   (dbgMask),
    .i_timeStamp (timeStamp),
    .i_debugBus  (i_debugBus),
    .i_grant     (dbgGrant),
    .o_pktValid  (dbgValid),
    .o_pkt       (dbgPkt),
    .o_dropCnt   (dropCnt)
  );

  traceFunnel uFunnel (
    .i_clk       (i_clk),
    .i_rstN      (i_rstN),
    .i_instValid (instValid),
    .i_instPkt   (instPkt),
    .i_dbgValid  (dbgValid),
    .i_dbgPkt    (dbgPkt),
    .o_instGrant (instGrant),
    .o_dbgGrant  (dbgGrant),
    .i_bufClear  (bufClear),
    .i_rdIdx     (rdIdx),
    .o_rdEntry   (rdEntry),
    .o_wrPtr     (wrPtr),
    .o_bufFull   (bufFull)
  );

endmodule

//--- verification/dfdTraceTb.sv
// No APB wait states, one trace instance, fixed seed; the run stops at the first error
`timescale 1ns/1ps

module dfdTraceTb;
  import dfdPkg::*;

  logic        clk;
  logic        rstN;
  logic        traceStart;
  logic        traceStop;
  logic [1:0]  iRetire;
  instType_e   iType;
  logic [31:0] iAddr;
  logic [31:0] debugBus;
  logic        active;
  logic        backpressure;
  apbAddr_t    pAddr;
  logic        pSel;
  logic        pEnable;
  logic        pWrite;
  apbData_t    pWData;
  apbData_t    pRData;
  logic        pReady;
  logic        pSlvErr;

  // Values applied at the next falling edge
  apbAddr_t    aAddr;
  logic        aSel;
  logic        aEn;
  logic        aWr;
  apbData_t    aData;
  logic [31:0] busNext;

  // ****************************************
  // Reference model state
  // ****************************************
  traceEntry_t instQ[$];
  logic [31:0] dbgChanges[$];
  retireCnt_t  accModel;
  logic        activeModel;
  logic        activePrev;
  logic [31:0] maskedPrev;
  logic        instEnModel;
  logic        dbgEnModel;
  logic [31:0] maskModel;

  dfdTraceTop dut (
    .i_clk          (clk),
    .i_rstN         (rstN),
    .i_traceStart   (traceStart),
    .i_traceStop    (traceStop),
    .i_iRetire      (iRetire),
    .i_iType        (iType),
    .i_iAddr        (iAddr),
    .i_debugBus     (debugBus),
    .o_active       (active),
    .o_backpressure (backpressure),
    .i_pAddr        (pAddr),
    .i_pSel         (pSel),
    .i_pEnable      (pEnable),
    .i_pWrite       (pWrite),
    .i_pWData       (pWData),
    .o_pRData       (pRData),
    .o_pReady       (pReady),
    .o_pSlvErr      (pSlvErr)
  );

  always #10 clk = ~clk;

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  // Drive at the falling edge, then model the rising edge that follows
  task automatic stepCycle(input logic start, input logic stop, input logic [1:0] ret,
                           input instType_e typ, input logic [31:0] addr);
    instType_e   typEff;
    logic        startEdge;
    logic [12:0] sum;
    logic [31:0] masked;
    @(negedge clk);
    assert (active === activeModel) else
      abortRun($sformatf("Error at %0t ns: o_active is %0b, expected %0b",
                         $time, active, activeModel));
    // Core holds typed retirements back while stalled
    typEff = backpressure ? itNone : typ;
    traceStart = start;
    traceStop  = stop;
    iRetire    = ret;
    iType      = typEff;
    iAddr      = addr;
    debugBus   = busNext;
    pAddr      = aAddr;
    pSel       = aSel;
    pEnable    = aEn;
    pWrite     = aWr;
    pWData     = aData;
    startEdge  = activeModel & ~activePrev;
    if (activeModel && instEnModel) begin
      sum = {1'b0, (startEdge ? 12'd0 : accModel)} + {11'd0, ret};
      if (sum > 13'd4095) begin
        sum = 13'd4095;
      end
      if (typEff != itNone) begin
        instQ.push_back({1'b0, typEff, sum[11:0], 16'h0, addr});
        accModel = '0;
      end else begin
        accModel = sum[11:0];
      end
    end else if (startEdge) begin
      accModel = '0;
    end
    masked = busNext & maskModel;
    if (activeModel && dbgEnModel && masked != maskedPrev) begin
      dbgChanges.push_back(masked);
    end
    maskedPrev  = masked;
    activePrev  = activeModel;
    activeModel = stop ? 1'b0 : (start ? 1'b1 : activeModel);
  endtask

  task automatic idleCycle();
    stepCycle(1'b0, 1'b0, 2'd0, itNone, 32'd0);
  endtask

  task automatic randomCycle(input int typedPct);
    instType_e typ;
    if ($urandom_range(0, 1) == 0) begin
      busNext = $urandom;
    end
    typ = ($urandom_range(0, 99) < typedPct) ? instType_e'(3'($urandom_range(1, 4))) : itNone;
    stepCycle(1'b0, 1'b0, 2'($urandom_range(0, 3)), typ, $urandom);
  endtask

  // ****************************************
  // APB access
  // ****************************************
  task automatic apbAccess(input apbAddr_t addr, input logic wr, input apbData_t wdata,
                           output apbData_t rdata, output logic slvErr);
    aAddr = addr;
    aWr   = wr;
    aData = wdata;
    aSel  = 1'b1;
    aEn   = 1'b0;
    idleCycle();
    aEn = 1'b1;
    idleCycle();
    // Sample mid access phase away from both edges
    #5;
    assert (pReady === 1'b1) else
      abortRun($sformatf("Error at %0t ns: o_pReady is %0b, expected 1", $time, pReady));
    rdata  = pRData;
    slvErr = pSlvErr;
    aSel   = 1'b0;
    aEn    = 1'b0;
    aWr    = 1'b0;
  endtask

  task automatic apbWrite(input apbAddr_t addr, input apbData_t data);
    apbData_t rd;
    logic     err;
    apbAccess(addr, 1'b1, data, rd, err);
    assert (err === 1'b0) else
      abortRun($sformatf("Error at %0t ns: o_pSlvErr is %0b on write to 0x%03h, expected 0",
                         $time, err, addr));
    if (addr == RegCtrl) begin
      instEnModel = data[0];
      dbgEnModel  = data[1];
    end else if (addr == RegDbgMask) begin
      maskModel = data;
    end
  endtask

  task automatic apbRead(input apbAddr_t addr, output apbData_t data);
    logic err;
    apbAccess(addr, 1'b0, 32'd0, data, err);
    assert (err === 1'b0) else
      abortRun($sformatf("Error at %0t ns: o_pSlvErr is %0b on read of 0x%03h, expected 0",
                         $time, err, addr));
  endtask

  task automatic readEntry(input int idx, output traceEntry_t e);
    apbData_t lo;
    apbData_t hi;
    apbWrite(RegRdIdx, apbData_t'(idx));
    apbRead(RegRdLo, lo);
    apbRead(RegRdHi, hi);
    e = {hi, lo};
  endtask

  // ****************************************
  // Waits
  // ****************************************
  task automatic waitNoBackpressure(input int maxCycles);
    int n;
    n = 0;
    do begin
      assert (n < maxCycles) else abortRun("Timeout waiting for o_backpressure to drop");
      idleCycle();
      n++;
    end while (backpressure);
  endtask

  // Pending slots drain into the buffer, then the pointer stops moving
  task automatic waitBufferSettled(output int ptr);
    apbData_t s1;
    apbData_t s2;
    int       n;
    waitNoBackpressure(50);
    apbRead(RegStatus, s1);
    apbRead(RegStatus, s2);
    n = 0;
    while (s1 != s2) begin
      assert (n < 20) else abortRun("Timeout waiting for the trace buffer to settle");
      s1 = s2;
      apbRead(RegStatus, s2);
      n++;
    end
    ptr = int'(s2[8:0]);
  endtask

  task automatic checkEntries(input int count);
    traceEntry_t e;
    traceEntry_t exp;
    apbData_t    drops;
    logic [15:0] lastTs;
    int          j;
    int          seen;
    j = 0;
    seen = 0;
    lastTs = '0;
    for (int i = 0; i < count; i++) begin
      readEntry(i, e);
      if (!e[63]) begin
        assert (instQ.size() > 0) else
          abortRun("Buffer holds more instruction entries than expected");
        exp = instQ.pop_front();
        assert ({e[63:48], e[31:0]} == {exp[63:48], exp[31:0]}) else
          abortRun($sformatf(
            "Error at %0t ns: trace entry %0d is 0x%016h, expected 0x%016h (ts ignored)",
            $time, i, e, exp));
        assert (e[47:32] >= lastTs) else
          abortRun($sformatf("Error at %0t ns: timestamp of entry %0d is 0x%0h, below 0x%0h",
                             $time, i, e[47:32], lastTs));
        lastTs = e[47:32];
      end else begin
        assert (e[62:48] == 15'd0) else
          abortRun($sformatf("Error at %0t ns: bits 62-48 of entry %0d are 0x%0h, expected 0x0",
                             $time, i, e[62:48]));
        while (j < dbgChanges.size() && dbgChanges[j] != e[31:0]) begin
          j++;
        end
        assert (j < dbgChanges.size()) else
          abortRun("Debug entry out of order or never changed to");
        j++;
        seen++;
      end
    end
    assert (instQ.size() == 0) else abortRun("Expected instruction entries are missing");
    apbRead(RegDropCnt, drops);
    assert (seen + drops == dbgChanges.size()) else
      abortRun($sformatf("Error at %0t ns: captured plus RegDropCnt is %0d, expected %0d",
                         $time, seen + drops, dbgChanges.size()));
  endtask

  // ****************************************
  // Test sequence
  // ****************************************
  initial begin
    apbData_t    rd;
    apbData_t    mask;
    apbData_t    dropsBefore;
    logic        err;
    logic        full;
    traceEntry_t e;
    int          ptr;
    int          ptr2;
    int          n;
    void'($urandom(85980));
    clk = 1'b0;
    rstN = 1'b0;
    traceStart = 1'b0;
    traceStop = 1'b0;
    iRetire = 2'd0;
    iType = itNone;
    iAddr = '0;
    debugBus = '0;
    pAddr = '0;
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
    pWData = '0;
    aAddr = '0;
    aSel = 1'b0;
    aEn = 1'b0;
    aWr = 1'b0;
    aData = '0;
    busNext = '0;
    accModel = '0;
    activeModel = 1'b0;
    activePrev = 1'b0;
    maskedPrev = '0;
    instEnModel = 1'b0;
    dbgEnModel = 1'b0;
    maskModel = '0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;

    // Reset state
    assert (active === 1'b0) else
      abortRun($sformatf("Error at %0t ns: o_active is %0b, expected 0", $time, active));
    assert (backpressure === 1'b0) else
      abortRun($sformatf("Error at %0t ns: o_backpressure is %0b, expected 0",
                         $time, backpressure));
    assert (pSlvErr === 1'b0) else
      abortRun($sformatf("Error at %0t ns: o_pSlvErr is %0b, expected 0", $time, pSlvErr));
    apbRead(RegStatus, rd);
    assert (rd == 32'd0) else
      abortRun($sformatf("Error at %0t ns: RegStatus is 0x%0h, expected 0x0", $time, rd));
    apbRead(RegCtrl, rd);
    assert (rd == 32'd0) else
      abortRun($sformatf("Error at %0t ns: RegCtrl is 0x%0h, expected 0x0", $time, rd));

    // Register readback and bus errors
    mask = $urandom;
    apbWrite(RegDbgMask, mask);
    apbRead(RegDbgMask, rd);
    assert (rd == mask) else
      abortRun($sformatf("Error at %0t ns: RegDbgMask is 0x%0h, expected 0x%0h",
                         $time, rd, mask));
    apbAccess(12'h024, 1'b0, 32'd0, rd, err);
    assert (err === 1'b1) else
      abortRun($sformatf("Error at %0t ns: o_pSlvErr is %0b on read of 0x024, expected 1",
                         $time, err));
    apbAccess(12'h3F0, 1'b1, 32'hFFFF_FFFF, rd, err);
    assert (err === 1'b1) else
      abortRun($sformatf("Error at %0t ns: o_pSlvErr is %0b on write to 0x3F0, expected 1",
                         $time, err));

    // Both paths with random retirements and bus changes
    apbWrite(RegCtrl, 32'd3);
    stepCycle(1'b1, 1'b0, 2'd0, itNone, 32'd0);
    repeat (120) randomCycle(40);
    // Leave retirements in the accumulator so the restart must clear them
    stepCycle(1'b0, 1'b1, 2'd3, itNone, 32'd0);
    waitBufferSettled(ptr);
    checkEntries(ptr);

    // Nothing new may land while stopped
    apbRead(RegDropCnt, dropsBefore);
    repeat (30) randomCycle(50);
    waitBufferSettled(ptr2);
    assert (ptr2 == ptr) else
      abortRun($sformatf("Error at %0t ns: write pointer is %0d, expected %0d",
                         $time, ptr2, ptr));
    apbRead(RegDropCnt, rd);
    assert (rd == dropsBefore) else
      abortRun($sformatf("Error at %0t ns: RegDropCnt is %0d, expected %0d",
                         $time, rd, dropsBefore));

    // Restart on the instruction path only so the count starts over
    apbWrite(RegCtrl, 32'd1);
    stepCycle(1'b1, 1'b0, 2'd0, itNone, 32'd0);
    repeat (6) stepCycle(1'b0, 1'b0, 2'($urandom_range(0, 3)), itNone, 32'd0);
    stepCycle(1'b0, 1'b0, 2'd1, itJump, $urandom);
    waitNoBackpressure(20);
    stepCycle(1'b0, 1'b1, 2'd0, itNone, 32'd0);
    waitBufferSettled(ptr2);
    assert (ptr2 == ptr + 1) else
      abortRun($sformatf("Error at %0t ns: write pointer is %0d, expected %0d",
                         $time, ptr2, ptr + 1));
    readEntry(ptr, e);
    assert ({e[63:48], e[31:0]} == {instQ[0][63:48], instQ[0][31:0]}) else
      abortRun($sformatf("Error at %0t ns: trace entry %0d is 0x%016h, expected 0x%016h",
                         $time, ptr, e, instQ[0]));
    void'(instQ.pop_front());

    // Fill the buffer
    stepCycle(1'b1, 1'b0, 2'd0, itNone, 32'd0);
    full = 1'b0;
    n = 0;
    while (!full) begin
      assert (n < 40) else abortRun("Timeout waiting for the trace buffer to fill");
      repeat (32) randomCycle(100);
      apbRead(RegStatus, rd);
      full = rd[9];
      n++;
    end
    assert (rd[8:0] == 9'd256) else
      abortRun($sformatf("Error at %0t ns: RegStatus pointer is %0d, expected 256",
                         $time, rd[8:0]));
    // Refills the slot in case the last buffer write just emptied it
    randomCycle(100);
    repeat (10) begin
      randomCycle(100);
      assert (backpressure === 1'b1) else
        abortRun($sformatf("Error at %0t ns: o_backpressure is %0b with the buffer full, %s",
                           $time, backpressure, "expected 1"));
    end

    // Clear lets the stalled packet into entry 0
    stepCycle(1'b0, 1'b1, 2'd0, itNone, 32'd0);
    apbWrite(RegClear, 32'd1);
    waitBufferSettled(ptr2);
    apbRead(RegStatus, rd);
    assert (rd[9:0] == 10'd1) else
      abortRun($sformatf("Error at %0t ns: RegStatus is 0x%0h, expected pointer 1", $time, rd));
    readEntry(0, e);
    assert ({e[63:48], e[31:0]} == {instQ[$][63:48], instQ[$][31:0]}) else
      abortRun($sformatf("Error at %0t ns: trace entry 0 is 0x%016h, expected 0x%016h",
                         $time, e, instQ[$]));

    $display("sim passed");
    $finish;
  end

endmodule

//--- dfdTrace.f
src/dfdPkg.sv
src/instTracePacker.sv
src/dbgSignalTracer.sv
src/traceFunnel.sv
src/traceRegs.sv
src/dfdTraceTop.sv
verification/dfdTraceTb.sv

//--- Makefile
# Verilator build and run for the debug trace unit
VERILATOR ?= verilator
TOP       ?= dfdTraceTb
FLIST     ?= dfdTrace.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
